/* all.f */
+incdir+src
src/ldst_cmd_pkg.sv
src/ldst_mem_pkg.sv
src/ldst_ctrl_fsm.sv
src/ldst_addr_gen.sv
src/ldst_ld_buffer.sv
src/ldst_scratch_mem.sv
src/ldst_top.sv
sim/tb_clock_gen.sv
sim/ldst_tb.sv

/* Bender.yml */
package:
  name: ldst_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ldst_cmd_pkg.sv
      - src/ldst_mem_pkg.sv
      - src/ldst_ctrl_fsm.sv
      - src/ldst_addr_gen.sv
      - src/ldst_ld_buffer.sv
      - src/ldst_scratch_mem.sv
      - src/ldst_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clock_gen.sv
      - sim/ldst_tb.sv

/* sim/ldst_tb.sv */
////////////////////
// Load/store unit testbench
// Seeded random commands against a memory model
// Write-back checker, stability check and watchdog
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_tb
	import ldst_cmd_pkg::*;
();

	localparam int WORDS = 1 << `LDST_ADDR_W;

	logic        clock;
	logic        arst_n;
	logic        cmd_valid;
	logic        cmd_ready;
	ldst_cmd_t   cmd;
	logic        wb_valid;
	logic        wb_ready;
	wb_beat_t    wb;
	logic        done;

	integer                    seed = 47;
	logic [`LDST_DATA_W-1:0]   model [WORDS]; // Mirror of the scratch memory
	wb_beat_t                  exp_q [$]; // Beats still owed by the DUT
	ldst_cmd_t                 cmd_list [$];
	bit                        long_list [$]; // Long wb_ready stalls per command
	bit                        long_stall = 1'b0;
	int                        cyc = 0;
	int                        last_hs_cyc = 0; // Cycle of the latest beat handshake
	int                        limit_cycles = 0;
	bit                        limit_set = 1'b0;
	bit                        held_valid = 1'b0;
	wb_beat_t                  held_beat;

	tb_clock_gen u_clock_gen (
		.clock  (clock),
		.arst_n (arst_n)
	);

	ldst_top dut (
		.clock     (clock),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.wb_valid  (wb_valid),
		.wb_ready  (wb_ready),
		.wb        (wb),
		.done      (done)
	);

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int elem_addr_of(input ldst_cmd_t c, input int i);
		return (int'(c.base) + i * int'(c.stride)) % WORDS;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic add_cmd(input ldst_op_e op, input int base, input int stride,
		input int count, input bit long);
		ldst_cmd_t c;
		c.op     = op;
		c.tag    = `LDST_TAG_W'(cmd_list.size()); // Issue number
		c.base   = `LDST_ADDR_W'(base);
		c.stride = `LDST_ADDR_W'(stride);
		c.count  = `LDST_ADDR_W'(count);
		c.data   = $random(seed);
		cmd_list.push_back(c);
		long_list.push_back(long);
	endtask

	////////////////////
	// One command, start to done
	task automatic run_cmd(input ldst_cmd_t c);
		wb_beat_t  beat;
		int        i;
		int        k;
		int        limit;
		bit        found;
		if (c.op == op_load) begin
			for (i = 0; i < c.count; i++) begin
				beat.tag  = c.tag;
				beat.data = model[elem_addr_of(c, i)];
				beat.last = (i == c.count - 1);
				exp_q.push_back(beat);
			end
		end
		@(posedge clock);
		cmd_valid <= 1'b1;
		cmd       <= c;
		found = 1'b0;
		while (!found) begin
			@(negedge clock);
			found = cmd_ready;
		end
		@(posedge clock); // Accept edge
		cmd_valid <= 1'b0;
		if (c.op == op_store) begin
			for (k = 1; k <= c.count; k++) begin
				@(negedge clock);
				check_value("done", done, 1'b0);
				check_value("wb_valid", wb_valid, 1'b0); // Stores return nothing
			end
			@(negedge clock);
			check_value("done", done, 1'b1);
			check_value("cmd_ready", cmd_ready, 1'b1);
			for (i = 0; i < c.count; i++)
				model[elem_addr_of(c, i)] = c.data;
		end else begin
			limit = c.count * 20 + 200;
			k     = 0;
			found = 1'b0;
			while (!found && k < limit) begin
				@(negedge clock);
				found = done;
				k++;
			end
			if (!found) begin
				$display("tests failed");
				$fatal(1, "load with tag %0d did not finish", c.tag);
			end
			check_value("beats_left", exp_q.size(), 0);
			check_value("cmd_ready", cmd_ready, 1'b1);
			if (c.count != 0)
				check_value("done_delay", cyc - last_hs_cyc, 1); // Cycle after last beat
			else
				check_value("done_cycles", k, 1); // Empty load ends at once
		end
		@(negedge clock);
		check_value("done", done, 1'b0); // Single pulse
	endtask

	always @(posedge clock)
		cyc <= cyc + 1;

	// Write-back consumer, random stretches
	initial begin : ready_driver
		int low_len;
		int high_len;
		wb_ready = 1'b0;
		wait (arst_n);
		forever begin
			if (long_stall) begin
				low_len  = 8 + rand_below(33);
				high_len = 1 + rand_below(6);
			end else begin
				low_len  = rand_below(4);
				high_len = 1 + rand_below(4);
			end
			repeat (low_len) begin
				@(posedge clock);
				wb_ready <= 1'b0;
			end
			repeat (high_len) begin
				@(posedge clock);
				wb_ready <= 1'b1;
			end
		end
	end

	////////////////////
	// Write-back checker
	always @(negedge clock) begin : wb_monitor
		wb_beat_t beat;
		if (arst_n) begin
			if (held_valid) begin
				check_value("wb_valid", wb_valid, 1'b1); // Held under back-pressure
				check_value("wb", wb, held_beat);
			end
			if (wb_valid && wb_ready) begin
				if (exp_q.size() == 0) begin
					$display("tests failed");
					$fatal(1, "write-back beat arrived when none was expected");
				end
				beat = exp_q.pop_front();
				check_value("wb.tag", wb.tag, beat.tag);
				check_value("wb.data", wb.data, beat.data);
				check_value("wb.last", wb.last, beat.last);
				last_hs_cyc = cyc;
			end
			held_valid = wb_valid && !wb_ready;
			held_beat  = wb;
		end
	end

	initial begin : watchdog
		wait (limit_set);
		repeat (limit_cycles) @(posedge clock);
		$display("tests failed");
		$fatal(1, "watchdog expired after %0d cycles", limit_cycles);
	end

	////////////////////
	// Main sequence
	initial begin : main_seq
		int i;
		int total;
		cmd_valid = 1'b0;
		cmd       = '0;
		add_cmd(op_store, 0, 1, WORDS - 1, 1'b0); // Whole memory but the top word
		add_cmd(op_store, WORDS - 1, 0, 1, 1'b0);
		for (i = 0; i < 12; i++)
			add_cmd(op_store, rand_below(WORDS), rand_below(WORDS), 1 + rand_below(40), 1'b0);
		for (i = 0; i < 12; i++)
			add_cmd(op_load, rand_below(WORDS), rand_below(WORDS), 1 + rand_below(40), 1'b0);
		for (i = 0; i < 16; i++)
			add_cmd(ldst_op_e'(rand_below(2)), rand_below(WORDS), rand_below(WORDS),
				1 + rand_below(24), 1'b1);
		add_cmd(op_store, 100, 3, 0, 1'b0); // Empty commands
		add_cmd(op_load, 100, 3, 0, 1'b0);
		add_cmd(op_load, 100, 3, 8, 1'b0);
		total = 0;
		foreach (cmd_list[j])
			total += cmd_list[j].count;
		limit_cycles = total * 20 + 60 * cmd_list.size() + 1000;
		limit_set    = 1'b1;

		wait (arst_n);
		@(negedge clock);
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("wb_valid", wb_valid, 1'b0);
		check_value("done", done, 1'b0);

		for (i = 0; i < cmd_list.size(); i++) begin
			long_stall = long_list[i];
			run_cmd(cmd_list[i]);
		end
		check_value("wb_valid", wb_valid, 1'b0);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
////////////////////
// Testbench clock and reset
// 10 ns clock, reset low for the first 3 cycles
////////////////////

`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock); // Release away from the active edge
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* src/ldst_top.sv */
////////////////////
// Load/store unit top
// FSM, address generator, scratch memory, load buffer
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_top
	import ldst_cmd_pkg::*;
	import ldst_mem_pkg::*;
(
	input  wire logic        clock,
	input  wire logic        arst_n,
	input  wire logic        cmd_valid,
	output logic             cmd_ready,
	input  wire ldst_cmd_t   cmd,
	output logic             wb_valid,
	input  wire logic        wb_ready,
	output wb_beat_t         wb,
	output logic             done
);

	logic                     seq_start;
	seq_ctl_t                 seq_ctl;
	logic                     seq_advance;
	logic [`LDST_ADDR_W-1:0]  elem_addr;
	logic                     elem_valid;
	logic                     elem_last;
	logic                     is_store;
	logic [`LDST_DATA_W-1:0]  st_data;
	logic [`LDST_TAG_W-1:0]   tag;
	logic                     mem_en;
	mem_req_t                 mem_req;
	logic [`LDST_DATA_W-1:0]  rdata;
	logic                     buf_pop;
	logic                     wb_last_pop;
	wb_beat_t                 push_beat;

	// Read-latency alignment
	logic                     rd_valid_q;
	logic                     rd_last_q;
	logic [`LDST_TAG_W-1:0]   rd_tag_q;

	assign mem_en      = seq_advance && elem_valid; // One access per step
	assign mem_req     = '{we: is_store, addr: elem_addr, wdata: st_data};
	assign wb_last_pop = buf_pop && wb.last;
	assign push_beat   = '{tag: rd_tag_q, data: rdata, last: rd_last_q};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= mem_en && !is_store;
	end

	always_ff @(posedge clock) begin
		rd_last_q <= elem_last;
		rd_tag_q  <= tag;
	end

	////////////////////
	// Blocks
	ldst_ctrl_fsm u_ctrl_fsm (
		.clock       (clock),
		.arst_n      (arst_n),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd),
		.seq_start   (seq_start),
		.seq_ctl     (seq_ctl),
		.seq_advance (seq_advance),
		.elem_valid  (elem_valid),
		.elem_last   (elem_last),
		.buf_pop     (buf_pop),
		.wb_last_pop (wb_last_pop),
		.is_store    (is_store),
		.st_data     (st_data),
		.tag         (tag),
		.done        (done)
	);

	ldst_addr_gen u_addr_gen (
		.clock       (clock),
		.arst_n      (arst_n),
		.seq_start   (seq_start),
		.seq_ctl     (seq_ctl),
		.seq_advance (seq_advance),
		.elem_addr   (elem_addr),
		.elem_valid  (elem_valid),
		.elem_last   (elem_last)
	);

	ldst_scratch_mem u_scratch_mem (
		.clock   (clock),
		.mem_en  (mem_en),
		.mem_req (mem_req),
		.rdata   (rdata)
	);

	ldst_ld_buffer u_ld_buffer (
		.clock     (clock),
		.arst_n    (arst_n),
		.push      (rd_valid_q),
		.push_beat (push_beat),
		.wb_valid  (wb_valid),
		.wb_ready  (wb_ready),
		.wb        (wb),
		.pop       (buf_pop)
	);

endmodule

`default_nettype wire

/* src/ldst_scratch_mem.sv */
////////////////////
// Scratch memory
// Single port, registered read
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_scratch_mem
	import ldst_mem_pkg::*;
(
	input  wire logic                     clock,
	input  wire logic                     mem_en,
	input  wire mem_req_t                 mem_req,
	output logic [`LDST_DATA_W-1:0]       rdata // Valid one cycle after a read
);

	localparam int WORDS = 1 << `LDST_ADDR_W;

	logic [`LDST_DATA_W-1:0]  mem_array [WORDS];

	always_ff @(posedge clock) begin
		if (mem_en) begin
			if (mem_req.we)
				mem_array[mem_req.addr] <= mem_req.wdata;
			else
				rdata <= mem_array[mem_req.addr];
		end
	end

endmodule

`default_nettype wire

/* src/ldst_ld_buffer.sv */
////////////////////
// Load buffer FIFO
// Holds loaded beats until write-back takes them
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_ld_buffer
	import ldst_cmd_pkg::*;
(
	input  wire logic        clock,
	input  wire logic        arst_n,
	input  wire logic        push,
	input  wire wb_beat_t    push_beat,
	output logic             wb_valid,
	input  wire logic        wb_ready,
	output wb_beat_t         wb, // Head entry
	output logic             pop // Write-back handshake fired
);

	localparam int DEPTH  = `LDST_BUF_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int FILL_W = $clog2(DEPTH + 1);

	wb_beat_t            beat_q [DEPTH];
	logic [PTR_W-1:0]    wr_ptr_q;
	logic [PTR_W-1:0]    rd_ptr_q;
	logic [FILL_W-1:0]   fill_q;
	logic                full;

	assign full     = (fill_q == FILL_W'(DEPTH));
	assign wb_valid = (fill_q != '0);
	assign wb       = beat_q[rd_ptr_q];
	assign pop      = wb_valid && wb_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			fill_q   <= '0;
		end else begin
			if (push)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
			if (pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
			case ({push, pop})
				2'b10:   fill_q <= fill_q + FILL_W'(1);
				2'b01:   fill_q <= fill_q - FILL_W'(1);
				default: fill_q <= fill_q;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			beat_q[wr_ptr_q] <= push_beat;
	end

	// Credits in the FSM keep this from firing
	a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
		push |-> !full);

endmodule

`default_nettype wire

/* src/ldst_addr_gen.sv */
////////////////////
// Strided address generator
// Steps base plus i times stride, flags the last element
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_addr_gen
	import ldst_mem_pkg::*;
(
	input  wire logic                     clock,
	input  wire logic                     arst_n,
	input  wire logic                     seq_start,
	input  wire seq_ctl_t                 seq_ctl,
	input  wire logic                     seq_advance,
	output logic [`LDST_ADDR_W-1:0]       elem_addr,
	output logic                          elem_valid,
	output logic                          elem_last
);

	logic [`LDST_ADDR_W-1:0]  stride_q;
	logic [`LDST_ADDR_W-1:0]  remain_q; // Elements not yet stepped
	logic                     step;

	assign elem_valid = (remain_q != '0);
	assign elem_last  = (remain_q == `LDST_ADDR_W'(1));
	assign step       = elem_valid && seq_advance;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			remain_q <= '0;
		end else if (seq_start) begin
			remain_q <= seq_ctl.count;
		end else if (step) begin
			remain_q <= remain_q - `LDST_ADDR_W'(1);
		end
	end

	// Address wraps at the memory size
	always_ff @(posedge clock) begin
		if (seq_start) begin
			elem_addr <= seq_ctl.base;
			stride_q  <= seq_ctl.stride;
		end else if (step) begin
			elem_addr <= elem_addr + stride_q;
		end
	end

	a_no_restart: assert property (@(posedge clock) disable iff (!arst_n)
		seq_start |-> (remain_q == '0));

endmodule

`default_nettype wire

/* src/ldst_ctrl_fsm.sv */
////////////////////
// Load/store control FSM
// Accepts commands, runs the sequence, counts load credits
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "ldst_defs.svh"

module ldst_ctrl_fsm
	import ldst_cmd_pkg::*;
	import ldst_mem_pkg::*;
(
	input  wire logic                     clock,
	input  wire logic                     arst_n,
	input  wire logic                     cmd_valid,
	output logic                          cmd_ready, // Idle or finishing
	input  wire ldst_cmd_t                cmd,
	output logic                          seq_start, // Load address generator
	output seq_ctl_t                      seq_ctl,
	output logic                          seq_advance, // Permit one step
	input  wire logic                     elem_valid,
	input  wire logic                     elem_last,
	input  wire logic                     buf_pop, // Beat left the buffer
	input  wire logic                     wb_last_pop, // Final beat left
	output logic                          is_store,
	output logic [`LDST_DATA_W-1:0]       st_data,
	output logic [`LDST_TAG_W-1:0]        tag,
	output logic                          done
);

	localparam int CRED_W = $clog2(`LDST_BUF_DEPTH + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_store,
		st_load,
		st_finish
	} state_e;

	state_e              state_q;
	state_e              state_d;
	logic                accept;
	logic                cred_inc;
	logic [CRED_W-1:0]   credits_q; // Reads in flight plus buffered beats

	assign cmd_ready = (state_q == st_idle) || (state_q == st_finish);
	assign accept    = cmd_valid && cmd_ready;
	assign done      = (state_q == st_finish);

	assign seq_start = accept;
	assign seq_ctl   = '{base: cmd.base, stride: cmd.stride, count: cmd.count};

	// Stores stream freely, loads wait for a free buffer slot
	assign seq_advance = (state_q == st_store) ||
		((state_q == st_load) && (credits_q < CRED_W'(`LDST_BUF_DEPTH)));
	assign cred_inc = (state_q == st_load) && seq_advance && elem_valid;

	////////////////////
	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle, st_finish: begin
				if (accept) begin
					if (cmd.count == '0)
						state_d = st_finish; // Nothing to access
					else if (cmd.op == op_store)
						state_d = st_store;
					else
						state_d = st_load;
				end else begin
					state_d = st_idle;
				end
			end
			st_store: begin
				if (elem_valid && elem_last)
					state_d = st_finish;
			end
			st_load: begin
				if (wb_last_pop)
					state_d = st_finish;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q   <= st_idle;
			credits_q <= '0;
			is_store  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (accept)
				is_store <= (cmd.op == op_store);
			case ({cred_inc, buf_pop})
				2'b10:   credits_q <= credits_q + CRED_W'(1);
				2'b01:   credits_q <= credits_q - CRED_W'(1);
				default: credits_q <= credits_q;
			endcase
		end
	end

	// Command payload
	always_ff @(posedge clock) begin
		if (accept) begin
			st_data <= cmd.data;
			tag     <= cmd.tag;
		end
	end

	a_credit_limit: assert property (@(posedge clock) disable iff (!arst_n)
		credits_q <= CRED_W'(`LDST_BUF_DEPTH));

endmodule

`default_nettype wire

/* src/ldst_mem_pkg.sv */
////////////////////
// Memory-side types
// Scratch memory request and sequence start
////////////////////

`default_nettype none

`include "ldst_defs.svh"

package ldst_mem_pkg;

	// One scratch memory access
	typedef struct packed {
		logic                     we; // Write when set, read otherwise
		logic [`LDST_ADDR_W-1:0]  addr;
		logic [`LDST_DATA_W-1:0]  wdata;
	} mem_req_t;

	// Start request to the address generator
	typedef struct packed {
		logic [`LDST_ADDR_W-1:0]  base;
		logic [`LDST_ADDR_W-1:0]  stride;
		logic [`LDST_ADDR_W-1:0]  count; // Zero means no element
	} seq_ctl_t;

endpackage

`default_nettype wire

/* src/ldst_cmd_pkg.sv */
////////////////////
// Command-side types
// Command from the pipeline and write-back beat
////////////////////

`default_nettype none

`include "ldst_defs.svh"

package ldst_cmd_pkg;

	// Access kind
	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} ldst_op_e;

	////////////////////
	// Command, shared by load and store
	typedef struct packed {
		ldst_op_e                 op; // Selects load or store
		logic [`LDST_TAG_W-1:0]   tag; // Issue number
		logic [`LDST_ADDR_W-1:0]  base; // First element address
		logic [`LDST_ADDR_W-1:0]  stride; // Step between elements
		logic [`LDST_ADDR_W-1:0]  count; // Number of elements
		logic [`LDST_DATA_W-1:0]  data; // Store word, unused on load
	} ldst_cmd_t;

	////////////////////
	// One write-back beat
	typedef struct packed {
		logic [`LDST_TAG_W-1:0]   tag;
		logic [`LDST_DATA_W-1:0]  data; // Loaded word
		logic                     last; // Final beat of the command
	} wb_beat_t;

endpackage

`default_nettype wire

/* src/ldst_defs.svh */
////////////////////
// Load/store unit parameters
// Widths of address, data and tag, load buffer depth
////////////////////

`ifndef LDST_DEFS_SVH
`define LDST_DEFS_SVH

// Word address into the 1024-word scratch memory
`define LDST_ADDR_W 10

`define LDST_DATA_W 32 // Data word
`define LDST_TAG_W 4 // Issue number

// Load buffer entries, also the load credit limit
`define LDST_BUF_DEPTH 8

`endif
